//--- bench/cart_loader_tb.sv
// Cartridge loader testbench
`timescale 1ns/1ps
`default_nettype none

module cart_loader_tb;
	import cart_pkg::*;
	import cheat_pkg::*;

	localparam int ROM_ADDR_W     = 22;
	localparam int HEADER_BYTES   = 512;
	localparam int MEM_BITS       = 10;
	localparam int MEM_SIZE       = 1 << MEM_BITS;
	localparam int STALL_CYCLES   = 20;
	localparam int TIMEOUT_CYCLES = 20000;  // ~1100 bytes at up to 12 cycles, plus margin

	logic        clk_sys;
	logic        reset;
	logic        ioctl_download;
	logic        ioctl_wr;
	dl_index_t   ioctl_index;
	rom_addr_t   ioctl_addr;
	byte_t       ioctl_dout;
	logic        ioctl_wait;
	logic        rom_req;
	logic        rom_ack = 1'b0;
	rom_addr_t   rom_waddr;
	byte_t       rom_wdata;
	rom_addr_t   rom_rd_addr;
	rom_addr_t   rom_map_addr;
	logic        gg;
	cheat_code_t code;
	logic        code_valid;
	logic        code_clear;

	int        seed = 46;
	int        cycle_count = 0;
	byte_t     mem [0:MEM_SIZE-1];       // ROM model storage
	byte_t     cheat_bytes [0:1][0:15];  // Two records as sent
	int        req_toggles = 0;
	int        rom_writes = 0;
	int        valid_pulses = 0;
	int        clear_pulses = 0;
	int        stall_hits = 0;
	logic      stall_enable = 1'b0;
	rom_addr_t stall_addr = '0;
	logic      last_req = 1'b0;
	logic      ack_busy = 1'b0;
	logic      ack_matched = 1'b0;
	logic      held_req = 1'b0;
	int        ack_delay = 0;

	cart_loader #(
		.ROM_ADDR_W   (ROM_ADDR_W),
		.HEADER_BYTES (HEADER_BYTES)
	) cart_loader_i (
		.clk_sys        (clk_sys),
		.reset          (reset),
		.ioctl_download (ioctl_download),
		.ioctl_wr       (ioctl_wr),
		.ioctl_index    (ioctl_index),
		.ioctl_addr     (ioctl_addr),
		.ioctl_dout     (ioctl_dout),
		.ioctl_wait     (ioctl_wait),
		.rom_req        (rom_req),
		.rom_ack        (rom_ack),
		.rom_waddr      (rom_waddr),
		.rom_wdata      (rom_wdata),
		.rom_rd_addr    (rom_rd_addr),
		.rom_map_addr   (rom_map_addr),
		.gg             (gg),
		.code           (code),
		.code_valid     (code_valid),
		.code_clear     (code_clear)
	);

	// ========================================================================
	// Checkers and expected values
	// ========================================================================

	task automatic report_failure(input string msg);
		$display("%s", msg);
		$display("TEST FAIL");
		$fatal(1);
	endtask

	task automatic check_value(input string name, input logic [127:0] got,
			input logic [127:0] expected);
		assert (got === expected)
			else report_failure($sformatf("Mismatch %s: got %0h expected %0h",
				name, got, expected));
	endtask

	task automatic check_count(input string name, input int got, input int expected);
		assert (got == expected)
			else report_failure($sformatf("Mismatch %s: got %0h expected %0h",
				name, got, expected));
	endtask

	function automatic byte_t image_byte(input int tag, input int addr);
		return byte_t'(addr ^ (addr >> 8) ^ (tag * 37));
	endfunction

	// OR of every address from 0 up to last
	function automatic rom_addr_t span_mask(input int last);
		rom_addr_t m;
		int        a;
		m = '0;
		for (a = 0; a <= last; a++)
			m = m | rom_addr_t'(a);
		return m;
	endfunction

	// Lane 0 is the least significant byte of a field
	function automatic code_word_t field_word(input logic rec, input logic [1:0] field);
		return {cheat_bytes[rec][{field, 2'd3}], cheat_bytes[rec][{field, 2'd2}],
			cheat_bytes[rec][{field, 2'd1}], cheat_bytes[rec][{field, 2'd0}]};
	endfunction

	function automatic cheat_code_t expected_record(input logic rec);
		cheat_code_t c;
		c.flags   = field_word(rec, 2'd0);
		c.address = field_word(rec, 2'd1);
		c.compare = field_word(rec, 2'd2);
		c.replace = field_word(rec, 2'd3);
		return c;
	endfunction

	// ========================================================================
	// Host driver
	// ========================================================================

	task automatic write_byte(input rom_addr_t addr, input byte_t data);
		logic is_code;
		is_code    = (ioctl_index == CODE_INDEX);
		ioctl_addr = addr;
		ioctl_dout = data;
		ioctl_wr   = 1'b1;
		@(negedge clk_sys);
		ioctl_wr = 1'b0;
		@(negedge clk_sys);
		// Two cycles after the strobe
		check_value("ioctl_wait", 128'(ioctl_wait), 128'(!is_code));
		if (addr == '0)
			check_value("code_clear", 128'(code_clear), 128'(1'b1));
		if (is_code && addr[3:0] == 4'hF) begin
			check_value("code_valid", 128'(code_valid), 128'(1'b1));
			check_value("code", code, expected_record(addr[4]));
		end
		while (ioctl_wait)
			@(negedge clk_sys);
	endtask

	task automatic load_image(input dl_index_t index, input int length, input int tag);
		int toggles_before;
		int a;
		toggles_before = req_toggles;
		ioctl_index    = index;
		ioctl_download = 1'b1;
		for (a = 0; a < length; a++)
			write_byte(rom_addr_t'(a), image_byte(tag, a));
		ioctl_download = 1'b0;
		repeat (3) @(negedge clk_sys);  // cart_end and header flag settle
		check_count("rom_req toggles", req_toggles - toggles_before, length);
		for (a = 0; a < length; a++)
			check_value($sformatf("mem[%0h]", a), 128'(mem[a[MEM_BITS-1:0]]),
				128'(image_byte(tag, a)));
	endtask

	task automatic load_cheats();
		int r;
		int b;
		int writes_before;
		int toggles_before;
		int valid_before;
		int clear_before;
		for (r = 0; r < 2; r++)
			for (b = 0; b < 16; b++)
				cheat_bytes[r[0]][b[3:0]] = byte_t'($random(seed));
		writes_before  = rom_writes;
		toggles_before = req_toggles;
		valid_before   = valid_pulses;
		clear_before   = clear_pulses;
		ioctl_index    = CODE_INDEX;
		ioctl_download = 1'b1;
		for (r = 0; r < 2; r++)
			for (b = 0; b < 16; b++)
				write_byte(rom_addr_t'(r * 16 + b), cheat_bytes[r[0]][b[3:0]]);
		ioctl_download = 1'b0;
		repeat (3) @(negedge clk_sys);
		check_count("code_valid pulses", valid_pulses - valid_before, 2);
		check_count("code_clear pulses", clear_pulses - clear_before, 1);
		check_count("ROM writes", rom_writes - writes_before, 0);
		check_count("rom_req toggles", req_toggles - toggles_before, 0);
	endtask

	// Mapped address shows one cycle after the read address
	task automatic check_mapping(input rom_addr_t rd, input rom_addr_t expected);
		rom_rd_addr = rd;
		@(negedge clk_sys);
		check_value("rom_map_addr", 128'(rom_map_addr), 128'(expected));
	endtask

	// ========================================================================
	// ROM model and monitors
	// ========================================================================

	always @(negedge clk_sys) begin
		if (reset) begin
			for (int i = 0; i < MEM_SIZE; i++)
				mem[i[MEM_BITS-1:0]] = byte_t'(i ^ (i >> 8)) ^ 8'hA5;
			ack_busy    = 1'b0;
			ack_matched = 1'b0;
		end else begin
			if (ack_matched) begin
				assert (!ioctl_wait)
					else report_failure("ioctl_wait still high one cycle after the acknowledge");
				ack_matched = 1'b0;
			end
			if (!ack_busy && rom_req != rom_ack) begin  // New request
				assert (rom_waddr < rom_addr_t'(MEM_SIZE))
					else report_failure("ROM write address outside the model memory");
				mem[rom_waddr[MEM_BITS-1:0]] = rom_wdata;
				rom_writes++;
				held_req = rom_req;
				ack_busy = 1'b1;
				if (stall_enable && rom_waddr == stall_addr) begin
					ack_delay = STALL_CYCLES;
					stall_hits++;
				end else begin
					ack_delay = $random(seed) & 7;
				end
			end
			if (ack_busy) begin
				assert (ioctl_wait && rom_req == held_req)
					else report_failure("Host released or request moved before the acknowledge");
				if (ack_delay == 0) begin
					rom_ack     = held_req;
					ack_busy    = 1'b0;
					ack_matched = 1'b1;
				end else begin
					ack_delay--;
				end
			end
		end
	end

	always @(negedge clk_sys) begin
		if (!reset) begin
			if (rom_req != last_req)
				req_toggles++;
			if (code_valid)
				valid_pulses++;
			if (code_clear)
				clear_pulses++;
		end
		last_req = rom_req;
	end

	// Cheat files never stall the host
	assert property (@(posedge clk_sys) disable iff (reset)
		(ioctl_download && ioctl_index == CODE_INDEX) |-> !ioctl_wait)
		else report_failure("ioctl_wait high during a cheat download");

	assert property (@(posedge clk_sys) disable iff (reset) code_valid |=> !code_valid)
		else report_failure("code_valid held for more than one cycle");

	always @(posedge clk_sys) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= TIMEOUT_CYCLES)
			report_failure("Timeout, the run did not finish within the cycle limit");
	end

	// ========================================================================
	// Clock and test sequence
	// ========================================================================

	initial begin
		clk_sys = 1'b0;
		forever #20 clk_sys = ~clk_sys;
	end

	initial begin
		int        i;
		int        stalls_before;
		rom_addr_t rd;
		rom_addr_t mask;
		reset          = 1'b1;
		ioctl_download = 1'b0;
		ioctl_wr       = 1'b0;
		ioctl_index    = '0;
		ioctl_addr     = '0;
		ioctl_dout     = '0;
		rom_rd_addr    = '0;
		repeat (3) @(posedge clk_sys);
		@(negedge clk_sys);
		reset = 1'b0;
		@(negedge clk_sys);
		check_value("ioctl_wait", 128'(ioctl_wait), '0);
		check_value("rom_req", 128'(rom_req), '0);
		check_value("code_valid", 128'(code_valid), '0);
		check_value("code_clear", 128'(code_clear), '0);
		check_value("gg", 128'(gg), '0);

		// 300-byte image with one held acknowledge
		stalls_before = stall_hits;
		stall_addr    = rom_addr_t'(100);
		stall_enable  = 1'b1;
		load_image(8'd1, 300, 1);
		stall_enable = 1'b0;
		check_count("stalled writes", stall_hits - stalls_before, 1);

		mask = span_mask(299);
		for (i = 0; i < 8; i++) begin
			rd = rom_addr_t'($random(seed));
			check_mapping(rd, rd & mask);
		end
		check_mapping(rom_addr_t'(299), rom_addr_t'(299) & mask);

		// 768 bytes, so a copier header is present
		load_image(8'd1, 768, 2);
		mask = span_mask(255);
		for (i = 0; i < 8; i++) begin
			rd = rom_addr_t'($random(seed));
			check_mapping(rd, (rd + rom_addr_t'(HEADER_BYTES)) & mask);
		end

		load_cheats();

		load_image(8'd2, 16, 3);  // Game Gear slot
		check_value("gg", 128'(gg), 128'(1'b1));
		load_image(8'd1, 16, 4);
		check_value("gg", 128'(gg), '0);

		$display("TEST PASS");
		$finish;
	end

endmodule : cart_loader_tb

`default_nettype wire

//--- build.f
design/cart_pkg.sv
design/cheat_pkg.sv
design/download_decode.sv
design/rom_write_seq.sv
design/cart_geometry.sv
design/cheat_code_asm.sv
design/cart_loader.sv
bench/cart_loader_tb.sv

//--- design/cart_geometry.sv
// Image size masks and read mapping
`timescale 1ns/1ps
`default_nettype none

module cart_geometry #(
	parameter int ROM_ADDR_W   = 22,
	parameter int HEADER_BYTES = 512
) (
	input  logic                clk_sys,
	input  logic                reset,
	input  logic                cart_beat_valid,
	input  logic                cart_end,
	input  logic                is_gg,
	input  cart_pkg::dl_beat_t  beat,
	input  cart_pkg::rom_addr_t rom_rd_addr,
	output cart_pkg::rom_addr_t rom_map_addr,
	output logic                gg
);

	// Bit of the final address that reveals a copier header
	localparam int HDR_BIT = $clog2(HEADER_BYTES);
	localparam logic [ROM_ADDR_W-1:0] HDR_OFFSET = ROM_ADDR_W'(HEADER_BYTES);

	logic [ROM_ADDR_W-1:0] beat_addr;
	logic [ROM_ADDR_W-1:0] plain_mask;   // OR of all addresses
	logic [ROM_ADDR_W-1:0] header_mask;  // Same, with the header removed
	logic [ROM_ADDR_W-1:0] map_next;
	logic                  header_en;

	assign beat_addr = beat.addr;

	// ========================================================================
	// Mask tracking
	// ========================================================================

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			plain_mask  <= '0;
			header_mask <= '0;
			header_en   <= 1'b0;
			gg          <= 1'b0;
		end else begin
			if (cart_beat_valid) begin
				if (beat_addr == '0)
					plain_mask <= '0;
				else
					plain_mask <= plain_mask | beat_addr;

				// Restarts at the first byte past the header
				if (beat_addr == HDR_OFFSET)
					header_mask <= '0;
				else
					header_mask <= header_mask | (beat_addr - HDR_OFFSET);

				gg <= is_gg;
			end

			if (cart_end)
				header_en <= beat_addr[HDR_BIT];  // Header adds 512 past a 1 KB multiple
		end
	end

	// ========================================================================
	// Read address mapping
	// ========================================================================

	always_comb begin
		if (header_en)
			map_next = (rom_rd_addr + HDR_OFFSET) & header_mask;
		else
			map_next = rom_rd_addr & plain_mask;
	end

	// Single register stage
	always_ff @(posedge clk_sys) begin
		rom_map_addr <= map_next;
	end

endmodule : cart_geometry

`default_nettype wire

//--- design/cart_loader.sv
// Cartridge and cheat loader top
`timescale 1ns/1ps
`default_nettype none

module cart_loader #(
	parameter int ROM_ADDR_W   = 22,
	parameter int HEADER_BYTES = 512
) (
	input  logic                   clk_sys,
	input  logic                   reset,

	// Host download port
	input  logic                   ioctl_download,
	input  logic                   ioctl_wr,
	input  cart_pkg::dl_index_t    ioctl_index,
	input  cart_pkg::rom_addr_t    ioctl_addr,
	input  cart_pkg::byte_t        ioctl_dout,
	output logic                   ioctl_wait,

	// ROM write side
	output logic                   rom_req,
	input  logic                   rom_ack,
	output cart_pkg::rom_addr_t    rom_waddr,
	output cart_pkg::byte_t        rom_wdata,

	// CPU read mapping
	input  cart_pkg::rom_addr_t    rom_rd_addr,
	output cart_pkg::rom_addr_t    rom_map_addr,
	output logic                   gg,

	// Cheat records
	output cheat_pkg::cheat_code_t code,
	output logic                   code_valid,
	output logic                   code_clear
);
	import cart_pkg::*;

	logic     cart_beat_valid;
	logic     code_beat_valid;
	dl_beat_t beat;
	logic     cart_start;
	logic     cart_end;
	logic     list_clear;
	logic     is_gg;

	download_decode download_decode_i (
		.clk_sys         (clk_sys),
		.reset           (reset),
		.ioctl_download  (ioctl_download),
		.ioctl_wr        (ioctl_wr),
		.ioctl_index     (ioctl_index),
		.ioctl_addr      (ioctl_addr),
		.ioctl_dout      (ioctl_dout),
		.cart_beat_valid (cart_beat_valid),
		.code_beat_valid (code_beat_valid),
		.beat            (beat),
		.cart_start      (cart_start),
		.cart_end        (cart_end),
		.list_clear      (list_clear),
		.is_gg           (is_gg)
	);

	rom_write_seq #(.ROM_ADDR_W(ROM_ADDR_W)) rom_write_seq_i (
		.clk_sys         (clk_sys),
		.reset           (reset),
		.cart_beat_valid (cart_beat_valid),
		.cart_start      (cart_start),
		.beat            (beat),
		.rom_ack         (rom_ack),
		.rom_req         (rom_req),
		.rom_waddr       (rom_waddr),
		.rom_wdata       (rom_wdata),
		.ioctl_wait      (ioctl_wait)
	);

	cart_geometry #(
		.ROM_ADDR_W   (ROM_ADDR_W),
		.HEADER_BYTES (HEADER_BYTES)
	) cart_geometry_i (
		.clk_sys         (clk_sys),
		.reset           (reset),
		.cart_beat_valid (cart_beat_valid),
		.cart_end        (cart_end),
		.is_gg           (is_gg),
		.beat            (beat),
		.rom_rd_addr     (rom_rd_addr),
		.rom_map_addr    (rom_map_addr),
		.gg              (gg)
	);

	cheat_code_asm cheat_code_asm_i (
		.clk_sys         (clk_sys),
		.reset           (reset),
		.code_beat_valid (code_beat_valid),
		.list_clear      (list_clear),
		.beat            (beat),
		.code            (code),
		.code_valid      (code_valid),
		.code_clear      (code_clear)
	);

endmodule : cart_loader

`default_nettype wire

//--- design/cart_pkg.sv
// Cartridge download types
`default_nettype none

package cart_pkg;

	// ========================================================================
	// Widths
	// ========================================================================

	localparam int ROM_ADDR_BITS = 22;  // 4 MB ROM window
	localparam int BYTE_BITS     = 8;
	localparam int INDEX_BITS    = 8;

	typedef logic [ROM_ADDR_BITS-1:0] rom_addr_t;  // ROM byte address
	typedef logic [BYTE_BITS-1:0]     byte_t;
	typedef logic [INDEX_BITS-1:0]    dl_index_t;  // Host menu slot of the download

	// One host write after classification
	typedef struct packed {
		rom_addr_t addr;
		byte_t     data;
	} dl_beat_t;

	// ========================================================================
	// Download index values
	// ========================================================================

	// All ones marks a cheat file
	localparam dl_index_t CODE_INDEX = 8'hFF;

	// Compared against the low five index bits only
	localparam logic [4:0] GG_INDEX = 5'd2;

endpackage : cart_pkg

`default_nettype wire

//--- design/cheat_code_asm.sv
// Cheat record assembler
`timescale 1ns/1ps
`default_nettype none

module cheat_code_asm (
	input  logic                  clk_sys,
	input  logic                  reset,
	input  logic                  code_beat_valid,
	input  logic                  list_clear,
	input  cart_pkg::dl_beat_t    beat,
	output cheat_pkg::cheat_code_t code,
	output logic                  code_valid,
	output logic                  code_clear
);
	import cheat_pkg::*;

	code_lane_t lane;       // Byte position within the record
	logic [1:0] field_sel;
	logic [4:0] bit_base;   // Start bit of the byte inside its word
	logic       last_byte;

	assign lane      = beat.addr[$bits(code_lane_t)-1:0];
	assign field_sel = lane[3:2];
	assign bit_base  = {lane[1:0], 3'b000};  // Least significant byte first
	assign last_byte = (lane == code_lane_t'(CODE_BYTES - 1));

	// ========================================================================
	// Byte steering
	// ========================================================================

	always_ff @(posedge clk_sys) begin
		if (code_beat_valid) begin
			case (field_sel)
				FIELD_FLAGS:   code.flags[bit_base +: 8]   <= beat.data;
				FIELD_ADDRESS: code.address[bit_base +: 8] <= beat.data;
				FIELD_COMPARE: code.compare[bit_base +: 8] <= beat.data;
				FIELD_REPLACE: code.replace[bit_base +: 8] <= beat.data;
			endcase
		end
	end

	// ========================================================================
	// Strobes
	// ========================================================================

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			code_valid <= 1'b0;
			code_clear <= 1'b0;
		end else begin
			// Record complete once byte 15 is in
			code_valid <= code_beat_valid & last_byte;
			code_clear <= list_clear;
		end
	end

endmodule : cheat_code_asm

`default_nettype wire

//--- design/cheat_pkg.sv
// Cheat record types
`default_nettype none

package cheat_pkg;

	localparam int CODE_WORD_W = 32;  // One field of a record
	localparam int CODE_BYTES  = 16;  // Bytes per record in the download

	typedef logic [CODE_WORD_W-1:0] code_word_t;

	// Byte position inside a record
	typedef logic [$clog2(CODE_BYTES)-1:0] code_lane_t;

	// Four words, flags in the top word
	//   127:96 flags
	//   95:64  address
	//   63:32  compare
	//   31:0   replace
	typedef struct packed {
		code_word_t flags;
		code_word_t address;
		code_word_t compare;
		code_word_t replace;
	} cheat_code_t;

	// Field select, taken from lane bits 3:2
	localparam logic [1:0] FIELD_FLAGS   = 2'd0;
	localparam logic [1:0] FIELD_ADDRESS = 2'd1;
	localparam logic [1:0] FIELD_COMPARE = 2'd2;
	localparam logic [1:0] FIELD_REPLACE = 2'd3;

endpackage : cheat_pkg

`default_nettype wire

//--- design/download_decode.sv
// Host download classifier
`timescale 1ns/1ps
`default_nettype none

module download_decode (
	input  logic                clk_sys,
	input  logic                reset,
	input  logic                ioctl_download,
	input  logic                ioctl_wr,
	input  cart_pkg::dl_index_t ioctl_index,
	input  cart_pkg::rom_addr_t ioctl_addr,
	input  cart_pkg::byte_t     ioctl_dout,
	output logic                cart_beat_valid,
	output logic                code_beat_valid,
	output cart_pkg::dl_beat_t  beat,
	output logic                cart_start,
	output logic                cart_end,
	output logic                list_clear,
	output logic                is_gg
);
	import cart_pkg::*;

	logic      code_sel;
	logic      cart_dl;
	logic      cart_dl_q;   // Level one cycle back, for edges
	rom_addr_t last_addr;   // Last cartridge address written

	assign code_sel = (ioctl_index == CODE_INDEX);
	assign cart_dl  = ioctl_download & ~code_sel;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			cart_dl_q       <= 1'b0;
			cart_beat_valid <= 1'b0;
			code_beat_valid <= 1'b0;
			cart_start      <= 1'b0;
			cart_end        <= 1'b0;
			list_clear      <= 1'b0;
			is_gg           <= 1'b0;
		end else begin
			cart_dl_q       <= cart_dl;
			cart_beat_valid <= cart_dl & ioctl_wr;
			code_beat_valid <= ioctl_download & code_sel & ioctl_wr;
			cart_start      <= cart_dl & ~cart_dl_q;
			cart_end        <= cart_dl_q & ~cart_dl;
			// First byte of any download empties the cheat list
			list_clear      <= ioctl_download & ioctl_wr & (ioctl_addr == '0);
			if (cart_dl & ioctl_wr)
				is_gg <= (ioctl_index[4:0] == GG_INDEX);
		end
	end

	// Beat payload
	always_ff @(posedge clk_sys) begin
		if (cart_dl & ioctl_wr)
			last_addr <= ioctl_addr;

		if (ioctl_download & ioctl_wr) begin
			beat.addr <= ioctl_addr;
			beat.data <= ioctl_dout;
		end else if (cart_dl_q & ~cart_dl) begin
			beat.addr <= last_addr;  // Reported alongside cart_end
		end
	end

endmodule : download_decode

`default_nettype wire

//--- design/rom_write_seq.sv
// ROM write handshake
`timescale 1ns/1ps
`default_nettype none

module rom_write_seq #(
	parameter int ROM_ADDR_W = 22
) (
	input  logic               clk_sys,
	input  logic               reset,
	input  logic               cart_beat_valid,
	input  logic               cart_start,
	input  cart_pkg::dl_beat_t beat,
	input  logic               rom_ack,
	output logic               rom_req,
	output cart_pkg::rom_addr_t rom_waddr,
	output cart_pkg::byte_t    rom_wdata,
	output logic               ioctl_wait
);
	import cart_pkg::*;

	typedef enum logic {
		WR_IDLE,
		WR_BUSY   // Request toggled, acknowledge not back yet
	} wr_state_t;

	wr_state_t             state;
	logic [ROM_ADDR_W-1:0] wr_addr;
	logic                  wr_done;

	// Acknowledge caught up with the request
	assign wr_done = (state == WR_BUSY) && (rom_ack == rom_req) && !cart_beat_valid;

	// ========================================================================
	// Request toggle and state
	// ========================================================================

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			state   <= WR_IDLE;
			rom_req <= 1'b0;
		end else begin
			if (cart_beat_valid) begin
				state   <= WR_BUSY;
				rom_req <= ~rom_req;
			end else if (wr_done) begin
				state <= WR_IDLE;
			end
		end
	end

	// ========================================================================
	// Write address
	// ========================================================================

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			wr_addr <= '0;
		end else if (cart_start) begin
			wr_addr <= '0;                 // New image starts at 0
		end else if (wr_done) begin
			wr_addr <= wr_addr + 1'b1;
		end
	end

	// Data held for the whole transfer
	always_ff @(posedge clk_sys) begin
		if (cart_beat_valid)
			rom_wdata <= beat.data;
	end

	assign rom_waddr  = rom_addr_t'(wr_addr);
	assign ioctl_wait = (state == WR_BUSY);  // Host stalls while busy

endmodule : rom_write_seq

`default_nettype wire

//--- run_sim.sh
#!/bin/sh
# Compile and run the cartridge loader testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f build.f --top-module cart_loader_tb

status=0
output=$(./obj_dir/Vcart_loader_tb 2>&1) || status=$?
printf '%s\n' "$output"

if printf '%s\n' "$output" | grep -q "TEST PASS"; then
	exit 0
fi
echo "Simulation did not pass (exit status $status)"
exit 1
